// ==== hw/ooo_pkg.sv ====
// Shared widths, opcode enum and the packet structs passed between core blocks
package ooo_pkg;

    localparam int XLEN          = 32;
    localparam int NUM_ARCH_REGS = 8;
    localparam int AREG_W        = $clog2(NUM_ARCH_REGS);
    localparam int ROB_SIZE_MAX  = 8;
    localparam int TAG_W         = $clog2(ROB_SIZE_MAX);

    // Hardwired zero register
    localparam logic [AREG_W-1:0] ZERO_REG = '0;

    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_XOR = 3'd3,
        OP_BNE = 3'd4
    } op_e;

    typedef struct packed {
        logic              valid;
        op_e               op;
        logic [AREG_W-1:0] dest;
        logic [AREG_W-1:0] src1;
        logic [AREG_W-1:0] src2;
    } dispatch_pkt_t;

    typedef struct packed {
        logic              ready;
        logic              mis_pred;
        logic [AREG_W-1:0] dest;
        logic [XLEN-1:0]   value;
    } rob_entry_t;

    typedef struct packed {
        logic             valid;
        op_e              op;
        logic [TAG_W-1:0] tag;
        logic [XLEN-1:0]  val1;
        logic [XLEN-1:0]  val2;
    } rs_issue_pkt_t;

    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
        logic [XLEN-1:0]  value;
        logic             mis_pred;
    } complete_pkt_t;

    typedef struct packed {
        logic              valid;
        logic              write_en;
        logic [AREG_W-1:0] dest;
        logic [XLEN-1:0]   value;
    } retire_pkt_t;

    typedef struct packed {
        logic             busy;
        logic [TAG_W-1:0] tag;
    } map_entry_t;

endpackage

// ==== hw/rob.sv ====
// Circular reorder buffer with completion writeback, in-order retire and squash
`timescale 1ns/1ns

module rob import ooo_pkg::*; #(
    parameter int ROB_SIZE = 8
) (
    input  logic             clock,
    input  logic             reset,
    input  dispatch_pkt_t    dispatch,
    input  complete_pkt_t    complete,
    input  logic [TAG_W-1:0] read_tag1,
    input  logic [TAG_W-1:0] read_tag2,
    output rob_entry_t       read_entry1,
    output rob_entry_t       read_entry2,
    output logic [TAG_W-1:0] tail,
    output logic [TAG_W-1:0] retire_tag,
    output logic             full,
    output retire_pkt_t      retire,
    output logic             squash
);

    localparam int CNT_W = $clog2(ROB_SIZE + 1);

    rob_entry_t       entries [ROB_SIZE];
    rob_entry_t       head_entry;
    logic [TAG_W-1:0] head;
    logic [CNT_W-1:0] count;
    logic             empty;
    logic             retire_valid;

    function automatic logic [TAG_W-1:0] next_ptr(input logic [TAG_W-1:0] ptr);
        return (ptr == TAG_W'(ROB_SIZE - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Slot lies between first_slot and first_slot + used, with wraparound
    function automatic logic occupied(input logic [TAG_W-1:0] tag,
                                      input logic [TAG_W-1:0] first_slot,
                                      input logic [CNT_W-1:0] used);
        int offset;
        offset = (int'(tag) - int'(first_slot) + ROB_SIZE) % ROB_SIZE;
        return offset < int'(used);
    endfunction

    assign read_entry1 = entries[read_tag1];
    assign read_entry2 = entries[read_tag2];

    assign head_entry   = entries[head];
    assign empty        = (count == '0);
    assign full         = (count == CNT_W'(ROB_SIZE));
    assign retire_valid = !empty && head_entry.ready;
    assign squash       = retire_valid && head_entry.mis_pred;
    assign retire_tag   = head;

    assign retire.valid    = retire_valid;
    assign retire.write_en = retire_valid && (head_entry.dest != ZERO_REG);
    assign retire.dest     = head_entry.dest;
    assign retire.value    = head_entry.value;

    // Head, tail and occupancy
    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (squash) begin
            // Drop everything younger than the branch
            head  <= tail;
            count <= '0;
        end else begin
            if (dispatch.valid) begin
                tail <= next_ptr(tail);
            end
            if (retire_valid) begin
                head <= next_ptr(head);
            end
            count <= count + CNT_W'(dispatch.valid) - CNT_W'(retire_valid);
        end
    end

    // Entry contents
    always_ff @(posedge clock) begin
        if (dispatch.valid && !squash) begin
            entries[tail].ready    <= 1'b0;
            entries[tail].mis_pred <= 1'b0;
            // Branches never write a register
            entries[tail].dest     <= (dispatch.op == OP_BNE) ? ZERO_REG : dispatch.dest;
            entries[tail].value    <= '0;
        end
        if (complete.valid) begin
            entries[complete.tag].ready    <= 1'b1;
            entries[complete.tag].value    <= complete.value;
            entries[complete.tag].mis_pred <= complete.mis_pred;
        end
    end

    a_no_dispatch_when_full: assert property (
        @(posedge clock) disable iff (reset)
        dispatch.valid |-> !full
    ) else $error("rob: dispatch while full");

    a_complete_to_live_slot: assert property (
        @(posedge clock) disable iff (reset)
        complete.valid |-> occupied(complete.tag, head, count)
    ) else $error("rob: completion to empty slot %0d", complete.tag);

endmodule

// ==== hw/map_table.sv ====
// Rename map from architectural register to the ROB tag of its newest producer
`timescale 1ns/1ns

module map_table import ooo_pkg::*; (
    input  logic             clock,
    input  logic             reset,
    input  dispatch_pkt_t    dispatch,
    input  logic [TAG_W-1:0] new_tag,
    input  retire_pkt_t      retire,
    input  logic [TAG_W-1:0] retire_tag,
    input  logic             squash,
    output map_entry_t       src1_map,
    output map_entry_t       src2_map
);

    map_entry_t map_q [NUM_ARCH_REGS];
    logic       dispatch_writes;

    assign src1_map = map_q[dispatch.src1];
    assign src2_map = map_q[dispatch.src2];

    assign dispatch_writes = dispatch.valid && (dispatch.op != OP_BNE)
                             && (dispatch.dest != ZERO_REG);

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            for (int i = 0; i < NUM_ARCH_REGS; i++) begin
                map_q[i] <= '0;
            end
        end else begin
            // Only the newest producer clears the mapping
            if (retire.write_en && map_q[retire.dest].tag == retire_tag) begin
                map_q[retire.dest].busy <= 1'b0;
            end
            // A same-cycle dispatch to the same register wins
            if (dispatch_writes) begin
                map_q[dispatch.dest].busy <= 1'b1;
                map_q[dispatch.dest].tag  <= new_tag;
            end
        end
    end

endmodule

// ==== hw/reservation_station.sv ====
// Reservation station with tag wakeup and lowest-index issue selection
`timescale 1ns/1ns

module reservation_station import ooo_pkg::*; #(
    parameter int RS_SIZE = 4
) (
    input  logic             clock,
    input  logic             reset,
    input  dispatch_pkt_t    dispatch,
    input  logic [TAG_W-1:0] new_tag,
    input  logic [XLEN-1:0]  val1,
    input  logic [XLEN-1:0]  val2,
    input  logic             rdy1,
    input  logic             rdy2,
    input  logic [TAG_W-1:0] wait_tag1,
    input  logic [TAG_W-1:0] wait_tag2,
    input  complete_pkt_t    complete,
    input  logic             squash,
    output logic             full,
    output rs_issue_pkt_t    issue
);

    localparam int IDX_W = $clog2(RS_SIZE);

    typedef struct packed {
        logic             valid;
        op_e              op;
        logic [TAG_W-1:0] tag;
        logic             rdy1;
        logic             rdy2;
        logic [TAG_W-1:0] wait_tag1;
        logic [TAG_W-1:0] wait_tag2;
        logic [XLEN-1:0]  val1;
        logic [XLEN-1:0]  val2;
    } rs_entry_t;

    rs_entry_t          entries [RS_SIZE];
    logic [RS_SIZE-1:0] wake1;
    logic [RS_SIZE-1:0] wake2;
    logic [RS_SIZE-1:0] ready_vec;
    logic [RS_SIZE-1:0] free_vec;
    logic [IDX_W-1:0]   issue_idx;
    logic [IDX_W-1:0]   free_idx;

    always_comb begin
        for (int i = 0; i < RS_SIZE; i++) begin
            wake1[i]     = complete.valid && !entries[i].rdy1
                           && (complete.tag == entries[i].wait_tag1);
            wake2[i]     = complete.valid && !entries[i].rdy2
                           && (complete.tag == entries[i].wait_tag2);
            ready_vec[i] = entries[i].valid && entries[i].rdy1 && entries[i].rdy2;
            free_vec[i]  = !entries[i].valid;
        end
    end

    // Scan downwards so the lowest index is left selected
    always_comb begin
        issue_idx = '0;
        free_idx  = '0;
        for (int i = RS_SIZE - 1; i >= 0; i--) begin
            if (ready_vec[i]) begin
                issue_idx = IDX_W'(i);
            end
            if (free_vec[i]) begin
                free_idx = IDX_W'(i);
            end
        end
    end

    assign full        = !(|free_vec);
    assign issue.valid = |ready_vec;
    assign issue.op    = entries[issue_idx].op;
    assign issue.tag   = entries[issue_idx].tag;
    assign issue.val1  = entries[issue_idx].val1;
    assign issue.val2  = entries[issue_idx].val2;

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            for (int i = 0; i < RS_SIZE; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else begin
            // Capture broadcast values into waiting operands
            for (int i = 0; i < RS_SIZE; i++) begin
                if (entries[i].valid && wake1[i]) begin
                    entries[i].rdy1 <= 1'b1;
                    entries[i].val1 <= complete.value;
                end
                if (entries[i].valid && wake2[i]) begin
                    entries[i].rdy2 <= 1'b1;
                    entries[i].val2 <= complete.value;
                end
            end
            if (issue.valid) begin
                entries[issue_idx].valid <= 1'b0;
            end
            if (dispatch.valid && !full) begin
                entries[free_idx] <= '{valid: 1'b1, op: dispatch.op, tag: new_tag,
                                       rdy1: rdy1, rdy2: rdy2,
                                       wait_tag1: wait_tag1, wait_tag2: wait_tag2,
                                       val1: val1, val2: val2};
            end
        end
    end

    // A waiting operand must not miss the broadcast of its own producer
    a_no_lost_wakeup: assert property (
        @(posedge clock) disable iff (reset)
        dispatch.valid && !full && complete.valid
        |-> (rdy1 || complete.tag != wait_tag1) && (rdy2 || complete.tag != wait_tag2)
    ) else $error("rs: operand dispatched waiting on tag %0d completing now",
                  complete.tag);

endmodule

// ==== hw/exec_unit.sv ====
// Single-cycle ALU and branch compare with a registered completion packet
`timescale 1ns/1ns

module exec_unit import ooo_pkg::*; (
    input  logic          clock,
    input  logic          reset,
    input  rs_issue_pkt_t issue,
    input  logic          squash,
    output complete_pkt_t complete
);

    logic [XLEN-1:0] result;
    logic            branch_taken;

    always_comb begin
        case (issue.op)
            OP_ADD:  result = issue.val1 + issue.val2;
            OP_SUB:  result = issue.val1 - issue.val2;
            OP_AND:  result = issue.val1 & issue.val2;
            OP_XOR:  result = issue.val1 ^ issue.val2;
            // BNE leaves no register value
            default: result = '0;
        endcase
    end

    // Predicted not taken, so a taken BNE is a mispredict
    assign branch_taken = (issue.op == OP_BNE) && (issue.val1 != issue.val2);

    always_ff @(posedge clock) begin
        if (reset) begin
            complete.valid <= 1'b0;
        end else begin
            complete.valid    <= issue.valid && !squash;
            complete.tag      <= issue.tag;
            complete.value    <= result;
            complete.mis_pred <= branch_taken;
        end
    end

endmodule

// ==== hw/arch_regfile.sv ====
// Architectural register file with two read ports and a retire write port
`timescale 1ns/1ns

module arch_regfile import ooo_pkg::*; (
    input  logic              clock,
    input  logic              reset,
    input  logic [AREG_W-1:0] read_idx1,
    input  logic [AREG_W-1:0] read_idx2,
    output logic [XLEN-1:0]   read_val1,
    output logic [XLEN-1:0]   read_val2,
    input  retire_pkt_t       retire
);

    logic [XLEN-1:0] regs [NUM_ARCH_REGS];

    // Zero register reads as zero whatever is stored
    assign read_val1 = (read_idx1 == ZERO_REG) ? '0 : regs[read_idx1];
    assign read_val2 = (read_idx2 == ZERO_REG) ? '0 : regs[read_idx2];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < NUM_ARCH_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (retire.valid && retire.write_en) begin
            regs[retire.dest] <= retire.value;
        end
    end

endmodule

// ==== hw/ooo_core.sv ====
// Top level of the back end with operand sourcing at dispatch
`timescale 1ns/1ns

module ooo_core import ooo_pkg::*; #(
    parameter int ROB_SIZE = 8,
    parameter int RS_SIZE  = 4
) (
    input  logic          clock,
    input  logic          reset,
    input  dispatch_pkt_t dispatch,
    output logic          dispatch_ready,
    output retire_pkt_t   retire,
    output logic          squash
);

    typedef struct packed {
        logic            ready;
        logic [XLEN-1:0] value;
    } operand_t;

    logic [TAG_W-1:0] new_tag;
    logic [TAG_W-1:0] retire_tag;
    logic             rob_full;
    logic             rs_full;
    map_entry_t       src1_map;
    map_entry_t       src2_map;
    rob_entry_t       rob_entry1;
    rob_entry_t       rob_entry2;
    logic [XLEN-1:0]  rf_val1;
    logic [XLEN-1:0]  rf_val2;
    complete_pkt_t    complete;
    rs_issue_pkt_t    issue;
    operand_t         opnd1;
    operand_t         opnd2;

    // Register file, then finished ROB entry, then same-cycle completion
    function automatic operand_t source_operand(input map_entry_t    src_map,
                                                input rob_entry_t    entry,
                                                input logic [XLEN-1:0] rf_val,
                                                input complete_pkt_t comp);
        operand_t opnd;
        opnd.ready = 1'b1;
        opnd.value = rf_val;
        if (src_map.busy) begin
            if (entry.ready) begin
                opnd.value = entry.value;
            end else if (comp.valid && comp.tag == src_map.tag) begin
                opnd.value = comp.value;
            end else begin
                // Wait in the RS on the producer tag
                opnd.ready = 1'b0;
                opnd.value = '0;
            end
        end
        return opnd;
    endfunction

    assign opnd1 = source_operand(src1_map, rob_entry1, rf_val1, complete);
    assign opnd2 = source_operand(src2_map, rob_entry2, rf_val2, complete);

    assign dispatch_ready = !rob_full && !rs_full;

    rob #(
        .ROB_SIZE(ROB_SIZE)
    ) u_rob (
        .clock       (clock),
        .reset       (reset),
        .dispatch    (dispatch),
        .complete    (complete),
        .read_tag1   (src1_map.tag),
        .read_tag2   (src2_map.tag),
        .read_entry1 (rob_entry1),
        .read_entry2 (rob_entry2),
        .tail        (new_tag),
        .retire_tag  (retire_tag),
        .full        (rob_full),
        .retire      (retire),
        .squash      (squash)
    );

    map_table u_map_table (
        .clock      (clock),
        .reset      (reset),
        .dispatch   (dispatch),
        .new_tag    (new_tag),
        .retire     (retire),
        .retire_tag (retire_tag),
        .squash     (squash),
        .src1_map   (src1_map),
        .src2_map   (src2_map)
    );

    reservation_station #(
        .RS_SIZE(RS_SIZE)
    ) u_rs (
        .clock     (clock),
        .reset     (reset),
        .dispatch  (dispatch),
        .new_tag   (new_tag),
        .val1      (opnd1.value),
        .val2      (opnd2.value),
        .rdy1      (opnd1.ready),
        .rdy2      (opnd2.ready),
        .wait_tag1 (src1_map.tag),
        .wait_tag2 (src2_map.tag),
        .complete  (complete),
        .squash    (squash),
        .full      (rs_full),
        .issue     (issue)
    );

    exec_unit u_exec (
        .clock    (clock),
        .reset    (reset),
        .issue    (issue),
        .squash   (squash),
        .complete (complete)
    );

    arch_regfile u_regfile (
        .clock     (clock),
        .reset     (reset),
        .read_idx1 (dispatch.src1),
        .read_idx2 (dispatch.src2),
        .read_val1 (rf_val1),
        .read_val2 (rf_val2),
        .retire    (retire)
    );

endmodule

// ==== verif/ooo_core_tb_model.svh ====
// Reference register model, expected-retire queue, value check and retire compare tasks
`ifndef OOO_CORE_TB_MODEL_SVH
`define OOO_CORE_TB_MODEL_SVH

// One stimulus row, imm replaces the first source when use_imm is set
typedef struct packed {
    op_e               op;
    logic [AREG_W-1:0] dest;
    logic [AREG_W-1:0] src1;
    logic [AREG_W-1:0] src2;
    logic              use_imm;
    logic [XLEN-1:0]   imm;
} row_t;

typedef struct packed {
    logic              squash;
    logic              write_en;
    logic [AREG_W-1:0] dest;
    logic [XLEN-1:0]   value;
} expected_t;

logic [XLEN-1:0] model_regs [NUM_ARCH_REGS];
expected_t       expected_q [$];
int              check_count;
int              error_count;

task automatic check_value(input string name, input logic [XLEN-1:0] actual,
                           input logic [XLEN-1:0] expected);
    check_count++;
    if (actual !== expected) begin
        $display("CHECK FAILED at %0t ns: %s is %h, expected %h",
                 $time, name, actual, expected);
        error_count++;
    end
endtask

// Executes one row in program order, returns 1 for a taken BNE
function automatic logic model_row(input row_t row);
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] result;
    expected_t       e;
    a = row.use_imm ? row.imm : model_regs[row.src1];
    b = model_regs[row.src2];
    case (row.op)
        OP_ADD:  result = a + b;
        OP_SUB:  result = a - b;
        OP_AND:  result = a & b;
        OP_XOR:  result = a ^ b;
        default: result = '0;
    endcase
    // Branch is predicted not taken
    e.squash   = (row.op == OP_BNE) && (a != b);
    e.write_en = (row.op != OP_BNE) && (row.dest != ZERO_REG);
    e.dest     = row.dest;
    e.value    = result;
    if (e.write_en) begin
        model_regs[row.dest] = result;
    end
    expected_q.push_back(e);
    return e.squash;
endfunction

task automatic compare_retire(input retire_pkt_t actual, input logic actual_squash,
                              input expected_t e);
    check_value("retire.write_en", actual.write_en, e.write_en);
    check_value("squash", actual_squash, e.squash);
    check_value("retire.value", actual.value, e.value);
    // Destination only matters when a register is written
    if (e.write_en) begin
        check_value("retire.dest", actual.dest, e.dest);
    end
endtask

`endif

// ==== verif/ooo_core_tb.sv ====
// Testbench for ooo_core with stimulus table, retire monitor and summary
`timescale 1ns/1ns

module ooo_core_tb import ooo_pkg::*; ();

    `include "ooo_core_tb_model.svh"

    localparam int CLOCK_HALF       = 4;
    localparam int DISPATCH_TIMEOUT = 200;
    localparam int DRAIN_TIMEOUT    = 500;
    localparam int QUIET_CYCLES     = 20;

    typedef struct packed {
        int   first;
        int   count;
        int   expected_retires;
        logic check_stall;
    } block_t;

    logic            clock;
    logic            reset;
    dispatch_pkt_t   dispatch;
    logic            dispatch_ready;
    retire_pkt_t     retire;
    logic            squash;

    row_t            table_rows [$];
    block_t          blocks [$];
    int              block_first;
    int              seed;
    logic [XLEN-1:0] inject_value;
    int              block_retires;
    int              retire_total;
    logic            timed_out;
    logic            stall_seen;
    expected_t       exp_item;

    ooo_core dut (
        .clock          (clock),
        .reset          (reset),
        .dispatch       (dispatch),
        .dispatch_ready (dispatch_ready),
        .retire         (retire),
        .squash         (squash)
    );

    initial clock = 1'b0;
    always #(CLOCK_HALF) clock = ~clock;

    task automatic add_row(input op_e op, input logic [AREG_W-1:0] dest,
                           input logic [AREG_W-1:0] src1, input logic [AREG_W-1:0] src2);
        table_rows.push_back('{op: op, dest: dest, src1: src1, src2: src2,
                               use_imm: 1'b0, imm: '0});
    endtask

    // Constant enters through the first register read port of r0
    task automatic add_imm_row(input op_e op, input logic [AREG_W-1:0] dest,
                               input logic [XLEN-1:0] imm);
        table_rows.push_back('{op: op, dest: dest, src1: ZERO_REG, src2: ZERO_REG,
                               use_imm: 1'b1, imm: imm});
    endtask

    task automatic end_block(input int expected_retires, input logic check_stall);
        block_t blk;
        blk.first            = block_first;
        blk.count            = table_rows.size() - block_first;
        blk.expected_retires = expected_retires;
        blk.check_stall      = check_stall;
        blocks.push_back(blk);
        block_first = table_rows.size();
    endtask

    task automatic build_table();
        block_first = 0;
        // Independent constants
        add_imm_row(OP_XOR, 3'd1, XLEN'($random(seed)));
        add_imm_row(OP_XOR, 3'd2, XLEN'($random(seed)));
        add_imm_row(OP_ADD, 3'd3, XLEN'($random(seed)));
        add_imm_row(OP_ADD, 3'd4, XLEN'($random(seed)));
        add_imm_row(OP_XOR, 3'd5, XLEN'($random(seed)));
        add_imm_row(OP_XOR, 3'd6, XLEN'($random(seed)));
        end_block(6, 1'b0);
        // Back-to-back dependent chain
        add_row(OP_ADD, 3'd1, 3'd1, 3'd2);
        add_row(OP_SUB, 3'd2, 3'd1, 3'd3);
        add_row(OP_XOR, 3'd3, 3'd2, 3'd1);
        add_row(OP_AND, 3'd4, 3'd3, 3'd3);
        add_row(OP_ADD, 3'd5, 3'd4, 3'd1);
        add_row(OP_ADD, 3'd6, 3'd5, 3'd5);
        end_block(6, 1'b0);
        // Long chain, more rows than ROB entries
        add_row(OP_ADD, 3'd1, 3'd1, 3'd2);
        add_row(OP_ADD, 3'd2, 3'd1, 3'd2);
        add_row(OP_XOR, 3'd3, 3'd2, 3'd1);
        add_row(OP_SUB, 3'd4, 3'd3, 3'd2);
        add_row(OP_ADD, 3'd5, 3'd4, 3'd3);
        add_row(OP_AND, 3'd6, 3'd5, 3'd4);
        add_row(OP_ADD, 3'd7, 3'd6, 3'd5);
        add_row(OP_XOR, 3'd1, 3'd7, 3'd6);
        add_row(OP_ADD, 3'd2, 3'd1, 3'd7);
        add_row(OP_SUB, 3'd3, 3'd2, 3'd1);
        add_row(OP_ADD, 3'd4, 3'd3, 3'd2);
        add_row(OP_XOR, 3'd5, 3'd4, 3'd3);
        end_block(12, 1'b1);
        // r7 = 1, so the BNE against r0 is taken
        add_imm_row(OP_XOR, 3'd7, 32'h1);
        add_row(OP_AND, 3'd7, 3'd7, 3'd7);
        add_row(OP_ADD, 3'd6, 3'd1, 3'd2);
        add_row(OP_BNE, 3'd0, 3'd7, 3'd0);
        add_row(OP_ADD, 3'd1, 3'd1, 3'd7);
        add_row(OP_XOR, 3'd2, 3'd2, 3'd2);
        add_row(OP_ADD, 3'd3, 3'd7, 3'd7);
        end_block(4, 1'b0);
        // Reads after squash, equal BNE and r0 writes
        add_row(OP_ADD, 3'd4, 3'd1, 3'd2);
        add_row(OP_XOR, 3'd5, 3'd3, 3'd7);
        add_row(OP_BNE, 3'd0, 3'd1, 3'd1);
        add_row(OP_ADD, 3'd0, 3'd4, 3'd5);
        add_row(OP_ADD, 3'd6, 3'd0, 3'd4);
        add_row(OP_SUB, 3'd0, 3'd6, 3'd6);
        add_row(OP_XOR, 3'd3, 3'd0, 3'd6);
        end_block(7, 1'b0);
    endtask

    task automatic drive_row(input row_t row);
        int waited;
        waited = 0;
        while (!dispatch_ready && waited < DISPATCH_TIMEOUT) begin
            dispatch.valid = 1'b0;
            stall_seen     = 1'b1;
            @(negedge clock);
            waited++;
        end
        if (!dispatch_ready) begin
            $display("Timeout at %0t ns: dispatch_ready stayed low for %0d cycles",
                     $time, waited);
            error_count++;
            timed_out = 1'b1;
        end else begin
            dispatch = '{valid: 1'b1, op: row.op, dest: row.dest,
                         src1: row.src1, src2: row.src2};
            inject_value = row.imm;
            if (row.use_imm) begin
                force dut.rf_val1 = inject_value;
            end
            @(negedge clock);
            if (row.use_imm) begin
                release dut.rf_val1;
            end
            dispatch.valid = 1'b0;
        end
    endtask

    task automatic run_block(input int b);
        block_t blk;
        int     r;
        int     waited;
        logic   squashed;
        blk           = blocks[b];
        block_retires = 0;
        stall_seen    = 1'b0;
        squashed      = 1'b0;
        // Expected retires stop at the first taken branch
        for (r = blk.first; r < blk.first + blk.count; r++) begin
            if (!squashed) begin
                squashed = model_row(table_rows[r]);
            end
        end
        for (r = blk.first; r < blk.first + blk.count; r++) begin
            if (!timed_out) begin
                drive_row(table_rows[r]);
            end
        end
        waited = 0;
        while (expected_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
            @(negedge clock);
            waited++;
        end
        if (expected_q.size() != 0) begin
            $display("Timeout at %0t ns: %0d instructions of block %0d never retired",
                     $time, expected_q.size(), b);
            error_count++;
            timed_out = 1'b1;
        end
        // Any retire in this window is flagged by the monitor
        repeat (QUIET_CYCLES) @(negedge clock);
        check_value("block retire count", block_retires, blk.expected_retires);
        if (blk.check_stall) begin
            check_value("dispatch_ready stall seen", stall_seen, 1'b1);
        end
        $display("Block %0d finished: %0d rows, %0d retires, %0d errors so far",
                 b, blk.count, block_retires, error_count);
    endtask

    // Retire monitor, sampled mid-cycle
    always @(negedge clock) begin
        if (!reset && retire.valid) begin
            block_retires++;
            retire_total++;
            if (expected_q.size() == 0) begin
                $display("Unexpected retire at %0t ns: no instruction was due to retire",
                         $time);
                error_count++;
            end else begin
                exp_item = expected_q.pop_front();
                compare_retire(retire, squash, exp_item);
            end
        end else if (!reset && squash) begin
            $display("Squash raised without a retire at %0t ns", $time);
            error_count++;
        end
    end

    initial begin
        seed          = 32'heac83ccb;
        reset         = 1'b1;
        dispatch      = '0;
        inject_value  = '0;
        check_count   = 0;
        error_count   = 0;
        retire_total  = 0;
        block_retires = 0;
        timed_out     = 1'b0;
        stall_seen    = 1'b0;
        for (int i = 0; i < NUM_ARCH_REGS; i++) begin
            model_regs[i] = '0;
        end
        build_table();
        repeat (3) @(negedge clock);
        reset = 1'b0;
        @(negedge clock);
        check_value("dispatch_ready", dispatch_ready, 1'b1);
        check_value("retire.valid", retire.valid, 1'b0);
        check_value("squash", squash, 1'b0);
        for (int b = 0; b < blocks.size(); b++) begin
            if (!timed_out) begin
                run_block(b);
            end
        end
        $display("Summary: %0d blocks, %0d retires, %0d checks, %0d errors",
                 blocks.size(), retire_total, check_count, error_count);
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+verif
hw/ooo_pkg.sv
hw/rob.sv
hw/map_table.sv
hw/reservation_station.sv
hw/exec_unit.sv
hw/arch_regfile.sv
hw/ooo_core.sv
verif/ooo_core_tb.sv
